//--- include/mesh_consts.svh
`ifndef MESH_CONSTS_SVH
`define MESH_CONSTS_SVH

////////////////////////////////////////////////////////////
// grid geometry

`define MESH_X           2
`define MESH_Y           2

// row 2 is the i/o row under the grid
`define MESH_COORD_W     2

`define MESH_IO_X        0
`define MESH_IO_Y        2

// local port plus four sides
`define MESH_PORTS       5

////////////////////////////////////////////////////////////
// tile memory

`define MESH_ADDR_W      8
`define MESH_DMEM_WORDS  256
`define MESH_DATA_W      32

`endif

//--- logic/mesh_noc_pkg.sv
`default_nettype none

`include "mesh_consts.svh"

package mesh_noc_pkg;

   // router port order, P is the local port
   typedef enum logic [2:0]
   {
      P = 3'd0,
      W = 3'd1,
      E = 3'd2,
      N = 3'd3,
      S = 3'd4
   } mesh_dir_e;

   // one x or y coordinate
   typedef logic [`MESH_COORD_W-1:0] mesh_coord_t;

endpackage

`default_nettype wire

//--- logic/mesh_packet_pkg.sv
`default_nettype none

`include "mesh_consts.svh"

package mesh_packet_pkg;

   import mesh_noc_pkg::*;

   typedef enum logic [1:0]
   {
      OP_STORE    = 2'd0,
      OP_LOAD     = 2'd1,
      OP_RET_ACK  = 2'd2,
      OP_RET_DATA = 2'd3
   } mesh_op_e;

   // op and dst fields line up in both views
   typedef struct packed {
      mesh_op_e                 op;
      mesh_coord_t              dst_x;
      mesh_coord_t              dst_y;
      mesh_coord_t              src_x;
      mesh_coord_t              src_y;
      logic [`MESH_ADDR_W-1:0]  addr;
      logic [`MESH_DATA_W-1:0]  data;
   } mesh_req_s;

   typedef struct packed {
      mesh_op_e                 op;
      mesh_coord_t              dst_x;
      mesh_coord_t              dst_y;
      mesh_coord_t              src_x;
      mesh_coord_t              src_y;
      logic [`MESH_ADDR_W-1:0]  pad;
      logic [`MESH_DATA_W-1:0]  data;
   } mesh_ret_s;

   typedef union packed {
      mesh_req_s req;
      mesh_ret_s ret;
   } mesh_packet_u;

endpackage

`default_nettype wire

//--- logic/mesh_link_if.sv
`timescale 1ns/1ps
`default_nettype none

// one direction of a valid/ready packet link
interface mesh_link_if
   import mesh_packet_pkg::*;
();

   logic         valid;
   logic         ready;
   mesh_packet_u pkt;

   // sender holds valid and pkt until the handshake
   modport sender
   (
      output valid,
      output pkt,
      input  ready
   );

   modport receiver
   (
      input  valid,
      input  pkt,
      output ready
   );

endinterface

`default_nettype wire

//--- logic/mesh_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "mesh_consts.svh"

module mesh_router
   import mesh_noc_pkg::*;
   import mesh_packet_pkg::*;
(
   input  logic          clk,
   input  logic          arst_n_i,
   input  mesh_coord_t   my_x_i,
   input  mesh_coord_t   my_y_i,
   mesh_link_if.receiver links_in  [`MESH_PORTS],
   mesh_link_if.sender   links_out [`MESH_PORTS]
);

   localparam int ports_lp = `MESH_PORTS;

   logic [ports_lp-1:0] in_v;
   logic [ports_lp-1:0] in_rdy;
   mesh_packet_u        in_pkt [ports_lp];

   logic [ports_lp-1:0] out_v;
   logic [ports_lp-1:0] out_rdy;
   mesh_packet_u        out_pkt [ports_lp];

   logic [ports_lp-1:0] buf_v;
   mesh_packet_u        buf_pkt [ports_lp];
   mesh_dir_e           buf_dir [ports_lp];

   logic [ports_lp-1:0] req_mat [ports_lp];
   logic [2:0]          sel     [ports_lp];
   logic [2:0]          rr_ptr  [ports_lp];
   logic [ports_lp-1:0] pop;

   // X first, then Y; out-of-grid columns fall off the east edge
   function automatic mesh_dir_e route_dir
   (
      input mesh_coord_t dst_x,
      input mesh_coord_t dst_y,
      input mesh_coord_t cur_x,
      input mesh_coord_t cur_y
   );
      if (dst_x > cur_x)
         route_dir = E;
      else if (dst_x < cur_x)
         route_dir = W;
      else if (dst_y > cur_y)
         route_dir = S;
      else if (dst_y < cur_y)
         route_dir = N;
      else
         route_dir = P;
   endfunction

   for (genvar i = 0; i < ports_lp; i++)
   begin : g_port
      assign in_v[i]            = links_in[i].valid;
      assign in_pkt[i]          = links_in[i].pkt;
      assign links_in[i].ready  = in_rdy[i];

      assign links_out[i].valid = out_v[i];
      assign links_out[i].pkt   = out_pkt[i];
      assign out_rdy[i]         = links_out[i].ready;
   end

   ////////////////////////////////////////////////////////////
   // route and arbitrate

   always_comb
   begin
      for (int i = 0; i < ports_lp; i++)
      begin
         buf_dir[i] = route_dir(buf_pkt[i].req.dst_x, buf_pkt[i].req.dst_y,
                                my_x_i, my_y_i);
      end
   end

   // round robin per output, search starts after the last winner
   always_comb
   begin : arbitrate
      int   idx;
      logic found;
      pop = '0;
      for (int o = 0; o < ports_lp; o++)
      begin
         for (int i = 0; i < ports_lp; i++)
         begin
            req_mat[o][i] = buf_v[i] && (int'(buf_dir[i]) == o);
         end
         found  = 1'b0;
         sel[o] = '0;
         for (int k = 1; k <= ports_lp; k++)
         begin
            idx = (int'(rr_ptr[o]) + k) % ports_lp;
            if (!found && req_mat[o][idx])
            begin
               found  = 1'b1;
               sel[o] = 3'(idx);
            end
         end
         out_v[o]   = found;
         out_pkt[o] = buf_pkt[sel[o]];
         if (found && out_rdy[o])
            pop[sel[o]] = 1'b1;
      end
   end

   // buffer takes a new packet in the cycle it drains
   assign in_rdy = ~buf_v | pop;

   ////////////////////////////////////////////////////////////
   // input buffers and pointers

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         buf_v  <= '0;
         rr_ptr <= '{default: '0};
      end
      else
      begin
         for (int i = 0; i < ports_lp; i++)
         begin
            if (in_rdy[i])
               buf_v[i] <= in_v[i];
         end
         for (int o = 0; o < ports_lp; o++)
         begin
            if (out_v[o] && out_rdy[o])
               rr_ptr[o] <= sel[o];
         end
      end
   end

   always_ff @(posedge clk)
   begin
      for (int i = 0; i < ports_lp; i++)
      begin
         if (in_v[i] && in_rdy[i])
            buf_pkt[i] <= in_pkt[i];
      end
   end

endmodule

`default_nettype wire

//--- logic/mesh_endpoint.sv
`timescale 1ns/1ps
`default_nettype none

`include "mesh_consts.svh"

module mesh_endpoint
   import mesh_noc_pkg::*;
   import mesh_packet_pkg::*;
(
   input  logic          clk,
   input  logic          arst_n_i,
   input  mesh_coord_t   my_x_i,
   input  mesh_coord_t   my_y_i,
   mesh_link_if.receiver req_in,
   mesh_link_if.sender   ret_out
);

   logic [`MESH_DATA_W-1:0] dmem [`MESH_DMEM_WORDS];

   logic                    s1_v;
   logic                    s2_v;
   logic                    ret_v;
   logic                    idle;
   logic                    accept;
   mesh_req_s               s1_req;
   mesh_req_s               s2_req;
   logic [`MESH_DATA_W-1:0] s2_rdata;
   mesh_ret_s               ret_d;
   mesh_packet_u            ret_pkt;

   // one request in flight until its return leaves
   assign idle         = !(s1_v || s2_v || ret_v);
   assign req_in.ready = idle;
   assign accept       = req_in.valid && idle;

   always_comb
   begin
      ret_d.op    = (s2_req.op == OP_STORE) ? OP_RET_ACK : OP_RET_DATA;
      ret_d.dst_x = s2_req.src_x;
      ret_d.dst_y = s2_req.src_y;
      ret_d.src_x = my_x_i;
      ret_d.src_y = my_y_i;
      ret_d.pad   = '0;
      ret_d.data  = (s2_req.op == OP_STORE) ? '0 : s2_rdata;
   end

   ////////////////////////////////////////////////////////////
   // accept, memory cycle, return register

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         s1_v  <= 1'b0;
         s2_v  <= 1'b0;
         ret_v <= 1'b0;
      end
      else
      begin
         s1_v <= accept;
         s2_v <= s1_v;
         if (s2_v)
            ret_v <= 1'b1;
         else if (ret_v && ret_out.ready)
            ret_v <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
         s1_req <= req_in.pkt.req;
      if (s1_v)
      begin
         if (s1_req.op == OP_STORE)
            dmem[s1_req.addr] <= s1_req.data;
         s2_rdata <= dmem[s1_req.addr];
         s2_req   <= s1_req;
      end
      if (s2_v)
         ret_pkt.ret <= ret_d;
   end

   assign ret_out.valid = ret_v;
   assign ret_out.pkt   = ret_pkt;

endmodule

`default_nettype wire

//--- logic/mesh_tile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mesh_consts.svh"

module mesh_tile
   import mesh_noc_pkg::*;
(
   input  logic          clk,
   input  logic          arst_n_i,
   input  mesh_coord_t   my_x_i,
   input  mesh_coord_t   my_y_i,
   mesh_link_if.receiver req_in  [W:S],
   mesh_link_if.sender   req_out [W:S],
   mesh_link_if.receiver ret_in  [W:S],
   mesh_link_if.sender   ret_out [W:S]
);

   mesh_link_if req_rtr_in  [`MESH_PORTS] ();
   mesh_link_if req_rtr_out [`MESH_PORTS] ();
   mesh_link_if ret_rtr_in  [`MESH_PORTS] ();
   mesh_link_if ret_rtr_out [`MESH_PORTS] ();

   // side links onto router ports 1..4
   for (genvar d = int'(W); d <= int'(S); d++)
   begin : g_side
      assign req_rtr_in[d].valid  = req_in[d].valid;
      assign req_rtr_in[d].pkt    = req_in[d].pkt;
      assign req_in[d].ready      = req_rtr_in[d].ready;
      assign req_out[d].valid     = req_rtr_out[d].valid;
      assign req_out[d].pkt       = req_rtr_out[d].pkt;
      assign req_rtr_out[d].ready = req_out[d].ready;

      assign ret_rtr_in[d].valid  = ret_in[d].valid;
      assign ret_rtr_in[d].pkt    = ret_in[d].pkt;
      assign ret_in[d].ready      = ret_rtr_in[d].ready;
      assign ret_out[d].valid     = ret_rtr_out[d].valid;
      assign ret_out[d].pkt       = ret_rtr_out[d].pkt;
      assign ret_rtr_out[d].ready = ret_out[d].ready;
   end

   mesh_router req_router_i
   (
      .clk,
      .arst_n_i,
      .my_x_i,
      .my_y_i,
      .links_in  (req_rtr_in),
      .links_out (req_rtr_out)
   );

   mesh_router ret_router_i
   (
      .clk,
      .arst_n_i,
      .my_x_i,
      .my_y_i,
      .links_in  (ret_rtr_in),
      .links_out (ret_rtr_out)
   );

   mesh_endpoint endpoint_i
   (
      .clk,
      .arst_n_i,
      .my_x_i,
      .my_y_i,
      .req_in  (req_rtr_out[P]),
      .ret_out (ret_rtr_in[P])
   );

   // nothing local injects requests or consumes returns
   assign req_rtr_in[P].valid  = 1'b0;
   assign req_rtr_in[P].pkt    = '0;
   assign ret_rtr_out[P].ready = 1'b0;

endmodule

`default_nettype wire

//--- logic/mesh_edge_sink.sv
`timescale 1ns/1ps
`default_nettype none

module mesh_edge_sink
(
   input  logic          clk,
   input  logic          arst_n_i,
   mesh_link_if.receiver link_in,
   output logic          misroute_o
);

   // always ready, strays never back up into the mesh
   assign link_in.ready = 1'b1;

   // sticky until reset
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         misroute_o <= 1'b0;
      else if (link_in.valid)
         misroute_o <= 1'b1;
   end

endmodule

`default_nettype wire

//--- logic/mesh_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "mesh_consts.svh"

module mesh_array
   import mesh_noc_pkg::*;
   import mesh_packet_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n_i,
   input  logic         req_valid_i,
   output logic         req_ready_o,
   input  mesh_packet_u req_pkt_i,
   output logic         rsp_valid_o,
   input  logic         rsp_ready_i,
   output mesh_packet_u rsp_pkt_o,
   output logic         misroute_o
);

   // two sink slots per side per tile, one per network
   localparam int sinks_lp = `MESH_X * `MESH_Y * 8;

   logic [sinks_lp-1:0] sink_flag;

   for (genvar y = 0; y < `MESH_Y; y++)
   begin : g_row
      for (genvar x = 0; x < `MESH_X; x++)
      begin : g_col
         mesh_link_if req_in  [W:S] ();
         mesh_link_if req_out [W:S] ();
         mesh_link_if ret_in  [W:S] ();
         mesh_link_if ret_out [W:S] ();

         mesh_tile tile_i
         (
            .clk,
            .arst_n_i,
            .my_x_i  (mesh_coord_t'(x)),
            .my_y_i  (mesh_coord_t'(y)),
            .req_in  (req_in),
            .req_out (req_out),
            .ret_in  (ret_in),
            .ret_out (ret_out)
         );

         for (genvar d = int'(W); d <= int'(S); d++)
         begin : g_side
            localparam int nx_lp = (d == int'(E)) ? x + 1 : (d == int'(W)) ? x - 1 : x;
            localparam int ny_lp = (d == int'(S)) ? y + 1 : (d == int'(N)) ? y - 1 : y;
            localparam int od_lp = (d == int'(W)) ? int'(E) :
                                   (d == int'(E)) ? int'(W) :
                                   (d == int'(N)) ? int'(S) : int'(N);
            localparam bit in_grid_lp = (nx_lp >= 0) && (nx_lp < `MESH_X) &&
                                        (ny_lp >= 0) && (ny_lp < `MESH_Y);
            localparam bit is_io_lp   = (nx_lp == `MESH_IO_X) && (ny_lp == `MESH_IO_Y);
            localparam int flag_lp    = (((y * `MESH_X) + x) * 4 + (d - 1)) * 2;

            if (is_io_lp)
            begin : g_io
               // i/o node: requests in, returns out
               assign req_in[d].valid  = req_valid_i;
               assign req_in[d].pkt    = req_pkt_i;
               assign req_ready_o      = req_in[d].ready;
               assign rsp_valid_o      = ret_out[d].valid;
               assign rsp_pkt_o        = ret_out[d].pkt;
               assign ret_out[d].ready = rsp_ready_i;
               assign ret_in[d].valid  = 1'b0;
               assign ret_in[d].pkt    = '0;

               mesh_edge_sink req_sink_i
               (
                  .clk,
                  .arst_n_i,
                  .link_in    (req_out[d]),
                  .misroute_o (sink_flag[flag_lp])
               );
               assign sink_flag[flag_lp+1] = 1'b0;
            end
            else if (in_grid_lp)
            begin : g_link
               assign req_in[d].valid  = g_row[ny_lp].g_col[nx_lp].req_out[od_lp].valid;
               assign req_in[d].pkt    = g_row[ny_lp].g_col[nx_lp].req_out[od_lp].pkt;
               assign req_out[d].ready = g_row[ny_lp].g_col[nx_lp].req_in[od_lp].ready;
               assign ret_in[d].valid  = g_row[ny_lp].g_col[nx_lp].ret_out[od_lp].valid;
               assign ret_in[d].pkt    = g_row[ny_lp].g_col[nx_lp].ret_out[od_lp].pkt;
               assign ret_out[d].ready = g_row[ny_lp].g_col[nx_lp].ret_in[od_lp].ready;
               assign sink_flag[flag_lp +: 2] = 2'b00;
            end
            else
            begin : g_edge
               assign req_in[d].valid = 1'b0;
               assign req_in[d].pkt   = '0;
               assign ret_in[d].valid = 1'b0;
               assign ret_in[d].pkt   = '0;

               mesh_edge_sink req_sink_i
               (
                  .clk,
                  .arst_n_i,
                  .link_in    (req_out[d]),
                  .misroute_o (sink_flag[flag_lp])
               );

               mesh_edge_sink ret_sink_i
               (
                  .clk,
                  .arst_n_i,
                  .link_in    (ret_out[d]),
                  .misroute_o (sink_flag[flag_lp+1])
               );
            end
         end
      end
   end

   assign misroute_o = |sink_flag;

endmodule

`default_nettype wire

//--- sim/mesh_array_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mesh_consts.svh"

module mesh_array_tb
   import mesh_noc_pkg::*;
   import mesh_packet_pkg::*;
();

   localparam int tiles_lp      = `MESH_X * `MESH_Y;
   localparam int send_limit_lp = 200;
   localparam int wait_limit_lp = 1000;
   localparam int rand_ops_lp   = 60;
   // about 30 cycles per request plus four drains and the misroute wait
   localparam int sends_lp      = 8 + 40 + 3 + rand_ops_lp;
   localparam int budget_lp     = 10 + sends_lp * 30 + 4 * (wait_limit_lp + 20) + 50;

   logic         clk;
   logic         arst_n_i;
   logic         req_valid_i;
   logic         req_ready_o;
   mesh_packet_u req_pkt_i;
   logic         rsp_valid_o;
   logic         rsp_ready_i;
   mesh_packet_u rsp_pkt_o;
   logic         misroute_o;

   logic [`MESH_DATA_W-1:0] ref_mem [tiles_lp][`MESH_DMEM_WORDS];
   mesh_packet_u            exp_q [$];
   mesh_packet_u            rsp_q [$];
   int                      errors;
   int                      checks;
   int                      tests;

   mesh_array mesh_array_i
   (
      .clk,
      .arst_n_i,
      .req_valid_i,
      .req_ready_o,
      .req_pkt_i,
      .rsp_valid_o,
      .rsp_ready_i,
      .rsp_pkt_o,
      .misroute_o
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // values at the falling edge decide the next handshake
   always @(negedge clk)
   begin
      if (arst_n_i && rsp_valid_o && rsp_ready_i)
         rsp_q.push_back(rsp_pkt_o);
   end

   initial
   begin
      #(budget_lp * 100 + 10_000);
      $display("timeout: run did not end within %0d cycles", budget_lp);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // packets and checks

   function automatic mesh_packet_u req_packet(mesh_op_e op, int x, int y, int addr,
                                               logic [`MESH_DATA_W-1:0] data);
      mesh_packet_u p;
      p.req.op    = op;
      p.req.dst_x = mesh_coord_t'(x);
      p.req.dst_y = mesh_coord_t'(y);
      p.req.src_x = `MESH_IO_X;
      p.req.src_y = `MESH_IO_Y;
      p.req.addr  = `MESH_ADDR_W'(addr);
      p.req.data  = data;
      return p;
   endfunction

   function automatic mesh_packet_u ret_packet(mesh_op_e op, int x, int y,
                                               logic [`MESH_DATA_W-1:0] data);
      mesh_packet_u p;
      p.ret.op    = op;
      p.ret.dst_x = `MESH_IO_X;
      p.ret.dst_y = `MESH_IO_Y;
      p.ret.src_x = mesh_coord_t'(x);
      p.ret.src_y = mesh_coord_t'(y);
      p.ret.pad   = '0;
      p.ret.data  = data;
      return p;
   endfunction

   task automatic expect_value(string name, logic [63:0] exp, logic [63:0] got);
      checks++;
      assert (got === exp) else
      begin
         errors++;
         $display("error %s: expected %h, actual %h", name, exp, got);
      end
   endtask

   task automatic expect_true(string name, bit cond, string what);
      checks++;
      assert (cond) else
      begin
         errors++;
         $display("%s: %s", name, what);
      end
   endtask

   task automatic report_test(string name, int errors_before);
      tests++;
      $display("%s: %s, %0d errors", name, (errors == errors_before) ? "ok" : "failed",
               errors - errors_before);
   endtask

   // holds valid until accepted, then books the expected return
   task automatic send_req(string name, mesh_op_e op, int x, int y, int addr,
                           logic [`MESH_DATA_W-1:0] data);
      int waited;
      int t;
      bit accepted;
      waited      = 0;
      t           = y * `MESH_X + x;
      req_pkt_i   = req_packet(op, x, y, addr, data);
      req_valid_i = 1'b1;
      @(negedge clk);
      while (!req_ready_o && waited < send_limit_lp)
      begin
         waited++;
         @(negedge clk);
      end
      accepted = req_ready_o;
      expect_true(name, accepted, "request was not accepted by the mesh");
      @(posedge clk);
      #10;
      req_valid_i = 1'b0;
      if (accepted && x < `MESH_X && y < `MESH_Y)
      begin
         if (op == OP_STORE)
         begin
            ref_mem[t][addr] = data;
            exp_q.push_back(ret_packet(OP_RET_ACK, x, y, '0));
         end
         else
            exp_q.push_back(ret_packet(OP_RET_DATA, x, y, ref_mem[t][addr]));
      end
   endtask

   // oldest outstanding entry of the same tile must match
   task automatic drain_returns(string name);
      int           waited;
      int           idx;
      mesh_packet_u got;
      waited = 0;
      while (exp_q.size() > 0 && waited < wait_limit_lp)
      begin
         if (rsp_q.size() > 0)
         begin
            got = rsp_q.pop_front();
            idx = -1;
            for (int i = exp_q.size() - 1; i >= 0; i--)
            begin
               if (exp_q[i].ret.src_x == got.ret.src_x &&
                   exp_q[i].ret.src_y == got.ret.src_y)
                  idx = i;
            end
            expect_true(name, idx >= 0, "return came from a tile with nothing outstanding");
            if (idx >= 0)
            begin
               expect_value(name, 64'(exp_q[idx]), 64'(got));
               exp_q.delete(idx);
            end
         end
         else
         begin
            @(posedge clk);
            waited++;
         end
      end
      expect_true(name, exp_q.size() == 0, "returns still missing after the wait");
      exp_q.delete();
      repeat (20) @(posedge clk);
      expect_true(name, rsp_q.size() == 0, "more returns arrived than requests were sent");
      rsp_q.delete();
      #10;
   endtask

   ////////////////////////////////////////////////////////////
   // directed tests

   task automatic reset_state();
      int e0;
      e0 = errors;
      @(negedge clk);
      expect_value("reset_state", 64'd0, 64'(rsp_valid_o));
      expect_value("reset_state", 64'd0, 64'(misroute_o));
      expect_value("reset_state", 64'd1, 64'(req_ready_o));
      @(posedge clk);
      #10;
      report_test("reset_state", e0);
   endtask

   task automatic store_load_all_tiles();
      int                      e0;
      int                      addr;
      logic [`MESH_DATA_W-1:0] data;
      e0 = errors;
      for (int y = 0; y < `MESH_Y; y++)
      begin
         for (int x = 0; x < `MESH_X; x++)
         begin
            addr = $urandom % `MESH_DMEM_WORDS;
            data = $urandom;
            send_req("store_load", OP_STORE, x, y, addr, data);
            send_req("store_load", OP_LOAD, x, y, addr, '0);
         end
      end
      drain_returns("store_load");
      report_test("store_load", e0);
   endtask

   task automatic back_pressure();
      int e0;
      int sent;
      int t;
      bit stalled;
      int last_addr [tiles_lp];
      e0          = errors;
      sent        = 0;
      stalled     = 1'b0;
      rsp_ready_i = 1'b0;
      while (!stalled && sent < 40)
      begin
         t = sent % tiles_lp;
         // ready is settled at the drive point
         if (!req_ready_o)
            stalled = 1'b1;
         else if (sent % 8 < 4)
         begin
            last_addr[t] = $urandom % `MESH_DMEM_WORDS;
            send_req("back_pressure", OP_STORE, t % `MESH_X, t / `MESH_X, last_addr[t],
                     $urandom);
            sent++;
         end
         else
         begin
            send_req("back_pressure", OP_LOAD, t % `MESH_X, t / `MESH_X, last_addr[t], '0);
            sent++;
         end
      end
      expect_true("back_pressure", stalled, "req_ready_o never fell with returns held");
      rsp_ready_i = 1'b1;
      drain_returns("back_pressure");
      report_test("back_pressure", e0);
   endtask

   task automatic misroute();
      int e0;
      e0 = errors;
      expect_value("misroute", 64'd0, 64'(misroute_o));
      send_req("misroute", OP_STORE, 3, 0, 5, 32'hdead_0003);
      repeat (50) @(posedge clk);
      #10;
      expect_true("misroute", rsp_q.size() == 0, "request to column 3 produced a return");
      expect_value("misroute", 64'd1, 64'(misroute_o));
      rsp_q.delete();
      send_req("misroute", OP_STORE, 1, 0, 9, 32'h0bad_c0de);
      send_req("misroute", OP_LOAD, 1, 0, 9, '0);
      drain_returns("misroute");
      report_test("misroute", e0);
   endtask

   task automatic random_traffic();
      int e0;
      int x;
      int y;
      int t;
      int addr;
      int pick;
      int stored_q [$];
      e0 = errors;
      for (int n = 0; n < rand_ops_lp; n++)
      begin
         if (stored_q.size() > 0 && ($urandom % 2 == 1))
         begin
            // load back a word stored earlier in this test
            pick = stored_q[$urandom % stored_q.size()];
            t    = pick / `MESH_DMEM_WORDS;
            addr = pick % `MESH_DMEM_WORDS;
            send_req("random_traffic", OP_LOAD, t % `MESH_X, t / `MESH_X, addr, '0);
         end
         else
         begin
            x    = $urandom % `MESH_X;
            y    = $urandom % `MESH_Y;
            addr = $urandom % `MESH_DMEM_WORDS;
            send_req("random_traffic", OP_STORE, x, y, addr, $urandom);
            stored_q.push_back((y * `MESH_X + x) * `MESH_DMEM_WORDS + addr);
         end
      end
      drain_returns("random_traffic");
      report_test("random_traffic", e0);
   endtask

   initial
   begin
      void'($urandom(32'h768e_b421));
      errors      = 0;
      checks      = 0;
      tests       = 0;
      arst_n_i    = 1'b0;
      req_valid_i = 1'b0;
      req_pkt_i   = '0;
      rsp_ready_i = 1'b1;
      repeat (4) @(posedge clk);
      #10;
      arst_n_i = 1'b1;
      reset_state();
      store_load_all_tiles();
      back_pressure();
      misroute();
      random_traffic();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- mesh_array.f
+incdir+include
logic/mesh_noc_pkg.sv
logic/mesh_packet_pkg.sv
logic/mesh_link_if.sv
logic/mesh_router.sv
logic/mesh_endpoint.sv
logic/mesh_tile.sv
logic/mesh_edge_sink.sv
logic/mesh_array.sv
sim/mesh_array_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the mesh testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module mesh_array_tb \
   -f mesh_array.f \
   -o mesh_array_sim

./obj_dir/mesh_array_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
   echo "simulation reported failure"
   exit 1
fi

echo "simulation finished without failure"
